//--- verilog/neander_pkg.sv
/*
 * Shared definitions for the 16-bit execution unit
 *   - data width of AC, X and operands
 *   - opcode encoding
 *   - command, flag and result structs
 */
package neander_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int DATA_W = 16;                 // AC, X and operand width

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        OP_LDI = 4'h0,                          // AC <= operand
        OP_ADD = 4'h1,                          // AC <= AC + operand, C = carry out
        OP_SUB = 4'h2,                          // AC <= AC - operand, C = no borrow
        OP_AND = 4'h3,
        OP_OR  = 4'h4,
        OP_XOR = 4'h5,
        OP_NOT = 4'h6,                          // Operand ignored
        OP_TAX = 4'h7,                          // X <= AC, flags kept
        OP_TXA = 4'h8,                          // AC <= X
        OP_INX = 4'h9,                          // X <= X + 1, wraps
        OP_DEX = 4'hA,                          // X <= X - 1, wraps
        OP_MUL = 4'hB                           // {X, AC} <= AC * operand
    } opcode_e;

    // --------------------------------------------------
    // Structs carried between blocks
    // --------------------------------------------------
    // Decoded command, 20 bits
    typedef struct packed {
        opcode_e           opcode;
        logic [DATA_W-1:0] operand;
    } cmd_t;

    typedef struct packed {
        logic n;                                // Bit 15 of AC
        logic z;                                // AC is zero
        logic c;                                // Carry / no borrow / wide product
    } flags_t;

    // Architectural state after one command, 35 bits
    typedef struct packed {
        logic [DATA_W-1:0] ac;
        logic [DATA_W-1:0] x;
        flags_t            flags;
    } result_t;

endpackage

//--- verilog/cmd_receiver.sv
/*
 * Input side of the execution unit
 *   - four-phase req/ack command port
 *   - one-entry hold register
 *   - valid/ready issue link to the core
 */
`timescale 1ns/1ps

module cmd_receiver (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_req,      // Four-phase request from environment
    input  neander_pkg::cmd_t  cmd,          // Stable while cmd_req is high
    input  logic               issue_ready,  // Core can take a command
    output logic               cmd_ack,
    output logic               issue_valid,  // Hold register is full
    output neander_pkg::cmd_t  issue_cmd
);
    import neander_pkg::*;

    logic accept;                            // Latch cmd this cycle
    logic release_ack;                       // Environment has dropped req
    logic issue_fire;                        // Core takes the held command

    // New req only when ack is low and the hold entry is empty
    assign accept      = cmd_req && !cmd_ack && !issue_valid;
    assign release_ack = cmd_ack && !cmd_req;
    assign issue_fire  = issue_valid && issue_ready;

    // --------------------------------------------------
    // Handshake control
    // --------------------------------------------------
    // cmd_ack low  -> waiting for req high
    // cmd_ack high -> waiting for req low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_ack     <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            if (issue_fire)
                issue_valid <= 1'b0;         // Entry handed to the core
            if (accept) begin
                cmd_ack     <= 1'b1;         // Phase 2, ack the latched command
                issue_valid <= 1'b1;
            end else if (release_ack) begin
                cmd_ack     <= 1'b0;         // Phase 4, ready for the next req
            end
        end
    end

    // Hold register payload
    always_ff @(posedge clk) begin
        if (accept)
            issue_cmd <= cmd;
    end

endmodule

//--- verilog/seq_multiplier.sv
/*
 * Sequential shift-and-add multiplier
 *   one multiplier bit per cycle, WIDTH step cycles
 *   done pulses for one cycle with the product
 */
`timescale 1ns/1ps

module seq_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,         // Load operands, steps follow
    input  logic [WIDTH-1:0] multiplicand,
    input  logic [WIDTH-1:0] multiplier,
    output logic [WIDTH-1:0] product_low,
    output logic [WIDTH-1:0] product_high,
    output logic             busy,
    output logic             done
);
    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [CNT_W-1:0] cnt;                   // Steps left
    logic [WIDTH-1:0] mcand_q;
    logic [WIDTH-1:0] hi_q;                  // Partial product, upper half
    logic [WIDTH-1:0] lo_q;                  // Multiplier bits shift out, product bits in
    logic [WIDTH:0]   partial;               // Upper half plus add carry

    // Add the multiplicand when the current multiplier bit is set
    assign partial = lo_q[0] ? ({1'b0, hi_q} + {1'b0, mcand_q}) : {1'b0, hi_q};

    assign product_low  = lo_q;
    assign product_high = hi_q;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;                    // Single-cycle pulse
            if (start && !busy) begin
                cnt  <= CNT_W'(WIDTH);
                busy <= 1'b1;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin  // Last step
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath, shift the whole product right each step
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand_q <= multiplicand;
            hi_q    <= '0;
            lo_q    <= multiplier;
        end else if (busy) begin
            {hi_q, lo_q} <= {partial, lo_q[WIDTH-1:1]};
        end
    end

endmodule

//--- verilog/exec_core.sv
/*
 * Processing part of the execution unit
 *   - AC, X and NZC registers
 *   - single-cycle ALU
 *   - issue FSM (idle, exec, mul_wait, hand_off)
 *   - sequential multiplier for MUL
 */
`timescale 1ns/1ps

module exec_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  neander_pkg::cmd_t    issue_cmd,
    input  logic                 res_ready,   // Sender buffer is free
    output logic                 issue_ready,
    output logic                 res_valid,
    output neander_pkg::result_t res
);
    import neander_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_MUL_WAIT, ST_HAND_OFF} state_e;

    state_e            state;
    cmd_t              cur_cmd;               // Command in execution
    logic [DATA_W-1:0] ac_q;
    logic [DATA_W-1:0] x_q;
    flags_t            flags_q;

    logic [DATA_W:0]   sum_wide;              // Extra bit holds carry out
    logic [DATA_W:0]   diff_wide;             // Extra bit holds borrow
    logic [DATA_W-1:0] new_ac;
    logic [DATA_W-1:0] new_x;
    logic              new_c;
    logic              ac_wr;                 // Opcode writes AC, so N and Z reload
    flags_t            new_flags;
    logic              is_mul;
    logic              mul_start;
    logic              mul_busy;
    logic              mul_done;
    logic [DATA_W-1:0] prod_lo;
    logic [DATA_W-1:0] prod_hi;
    logic              commit;                // Write AC, X and flags

    assign is_mul      = (cur_cmd.opcode == OP_MUL);
    assign issue_ready = (state == ST_IDLE);
    assign res_valid   = (state == ST_HAND_OFF);
    assign res         = '{ac: ac_q, x: x_q, flags: flags_q};

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    assign sum_wide  = {1'b0, ac_q} + {1'b0, cur_cmd.operand};
    assign diff_wide = {1'b0, ac_q} - {1'b0, cur_cmd.operand};

    always_comb begin
        new_ac = ac_q;
        new_x  = x_q;
        new_c  = flags_q.c;                   // C kept unless the opcode sets it
        ac_wr  = 1'b1;
        case (cur_cmd.opcode)
            OP_LDI: new_ac = cur_cmd.operand;
            OP_ADD: begin
                new_ac = sum_wide[DATA_W-1:0];
                new_c  = sum_wide[DATA_W];
            end
            OP_SUB: begin
                new_ac = diff_wide[DATA_W-1:0];
                new_c  = !diff_wide[DATA_W];  // Set when AC >= operand
            end
            OP_AND: new_ac = ac_q & cur_cmd.operand;
            OP_OR:  new_ac = ac_q | cur_cmd.operand;
            OP_XOR: new_ac = ac_q ^ cur_cmd.operand;
            OP_NOT: new_ac = ~ac_q;
            OP_TXA: new_ac = x_q;
            OP_TAX: begin
                new_x = ac_q;
                ac_wr = 1'b0;
            end
            OP_INX: begin
                new_x = x_q + 1'b1;           // Wraps at 16 bits
                ac_wr = 1'b0;
            end
            OP_DEX: begin
                new_x = x_q - 1'b1;
                ac_wr = 1'b0;
            end
            OP_MUL: begin
                new_ac = prod_lo;             // Low word to AC, high word to X
                new_x  = prod_hi;
                new_c  = |prod_hi;
            end
            default: ac_wr = 1'b0;            // Unused encodings change nothing
        endcase
    end

    // X-only opcodes leave every flag alone
    assign new_flags = ac_wr ? '{n: new_ac[DATA_W-1], z: (new_ac == '0), c: new_c} : flags_q;

    assign mul_start = (state == ST_EXEC) && is_mul && !mul_busy;
    assign commit    = ((state == ST_EXEC) && !is_mul) || ((state == ST_MUL_WAIT) && mul_done);

    seq_multiplier #(
        .WIDTH (DATA_W)
    ) u_mul (
        .clk          (clk),
        .reset        (reset),
        .start        (mul_start),
        .multiplicand (ac_q),
        .multiplier   (cur_cmd.operand),
        .product_low  (prod_lo),
        .product_high (prod_hi),
        .busy         (mul_busy),
        .done         (mul_done)
    );

    // --------------------------------------------------
    // Issue FSM and architectural registers
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_IDLE;
            ac_q    <= '0;
            x_q     <= '0;
            flags_q <= '0;
        end else begin
            if (commit) begin
                ac_q    <= new_ac;
                x_q     <= new_x;
                flags_q <= new_flags;
            end
            case (state)
                ST_IDLE:     if (issue_valid) state <= ST_EXEC;
                ST_EXEC:     state <= is_mul ? ST_MUL_WAIT : ST_HAND_OFF;
                ST_MUL_WAIT: if (mul_done) state <= ST_HAND_OFF;
                ST_HAND_OFF: if (res_ready) state <= ST_IDLE;  // Result taken by sender
                default:     state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready)
            cur_cmd <= issue_cmd;
    end

endmodule

//--- verilog/result_sender.sv
/*
 * Output side of the execution unit
 *   - one-entry result buffer
 *   - four-phase req/ack result port
 */
`timescale 1ns/1ps

module result_sender (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 res_valid,   // Core presents a result
    input  neander_pkg::result_t res,
    input  logic                 rsp_ack,     // Four-phase ack from environment
    output logic                 res_ready,   // Buffer empty
    output logic                 rsp_req,
    output neander_pkg::result_t rsp
);
    import neander_pkg::*;

    logic load;                              // Transfer from the core
    logic ack_high;                          // Phase 2 seen
    logic ack_low;                           // Phase 4 seen after req dropped

    assign load     = res_valid && res_ready;
    assign ack_high = rsp_req && rsp_ack;
    assign ack_low  = !res_ready && !rsp_req && !rsp_ack;

    // --------------------------------------------------
    // Handshake control
    // --------------------------------------------------
    // res_ready high             -> buffer empty
    // res_ready low, req high    -> waiting for ack high
    // res_ready low, req low     -> waiting for ack low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_ready <= 1'b1;
            rsp_req   <= 1'b0;
        end else begin
            if (load) begin
                res_ready <= 1'b0;
                rsp_req   <= 1'b1;           // Phase 1
            end else if (ack_high) begin
                rsp_req   <= 1'b0;           // Phase 3
            end else if (ack_low) begin
                res_ready <= 1'b1;           // Handshake done, reopen buffer
            end
        end
    end

    // Buffer holds until res_ready reopens, past the fall of rsp_ack
    always_ff @(posedge clk) begin
        if (load)
            rsp <= res;
    end

endmodule

//--- verilog/neander_exec_top.sv
/*
 * Top level of the execution unit
 *   input side -> processing part -> output side
 */
`timescale 1ns/1ps

module neander_exec_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_req,
    input  neander_pkg::cmd_t    cmd,
    input  logic                 rsp_ack,
    output logic                 cmd_ack,
    output logic                 rsp_req,
    output neander_pkg::result_t rsp
);
    import neander_pkg::*;

    logic    issue_valid;                    // Receiver to core
    logic    issue_ready;
    cmd_t    issue_cmd;
    logic    res_valid;                      // Core to sender
    logic    res_ready;
    result_t res;

    cmd_receiver u_rx (
        .clk         (clk),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .issue_ready (issue_ready),
        .cmd_ack     (cmd_ack),
        .issue_valid (issue_valid),
        .issue_cmd   (issue_cmd)
    );

    exec_core u_core (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_cmd   (issue_cmd),
        .res_ready   (res_ready),
        .issue_ready (issue_ready),
        .res_valid   (res_valid),
        .res         (res)
    );

    result_sender u_tx (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res       (res),
        .rsp_ack   (rsp_ack),
        .res_ready (res_ready),
        .rsp_req   (rsp_req),
        .rsp       (rsp)
    );

endmodule

//--- include/tb_vectors.svh
/*
 * Stimulus and expected-value table for the execution unit
 *   - row type: command plus AC, X and NZC expected after it
 *   - rows in program order, starting from the all-zero reset state
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
    opcode_e           opcode;
    logic [DATA_W-1:0] operand;
    logic [DATA_W-1:0] ac;                   // Expected after the command
    logic [DATA_W-1:0] x;
    logic              n;
    logic              z;
    logic              c;
} vec_t;

localparam int NUM_VECS = 26;

// Columns: opcode, operand, ac, x, n, z, c
localparam vec_t VECTORS [NUM_VECS] = '{
    '{OP_LDI, 16'h0000, 16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0},  // Zero load from reset state
    '{OP_LDI, 16'h8001, 16'h8001, 16'h0000, 1'b1, 1'b0, 1'b0},  // Negative value sets N
    '{OP_TAX, 16'h0000, 16'h8001, 16'h8001, 1'b1, 1'b0, 1'b0},
    '{OP_LDI, 16'h0000, 16'h0000, 16'h8001, 1'b0, 1'b1, 1'b0},
    '{OP_TXA, 16'h0000, 16'h8001, 16'h8001, 1'b1, 1'b0, 1'b0},  // N and Z reload from X
    '{OP_LDI, 16'hFFFF, 16'hFFFF, 16'h8001, 1'b1, 1'b0, 1'b0},
    '{OP_TAX, 16'h0000, 16'hFFFF, 16'hFFFF, 1'b1, 1'b0, 1'b0},
    '{OP_INX, 16'h0000, 16'hFFFF, 16'h0000, 1'b1, 1'b0, 1'b0},  // Wraps to 0, flags kept
    '{OP_DEX, 16'h0000, 16'hFFFF, 16'hFFFF, 1'b1, 1'b0, 1'b0},
    '{OP_LDI, 16'hF000, 16'hF000, 16'hFFFF, 1'b1, 1'b0, 1'b0},
    '{OP_ADD, 16'h2000, 16'h1000, 16'hFFFF, 1'b0, 1'b0, 1'b1},  // Carry out of bit 15
    '{OP_SUB, 16'h3000, 16'hE000, 16'hFFFF, 1'b1, 1'b0, 1'b0},  // Borrow clears C
    '{OP_SUB, 16'hE000, 16'h0000, 16'hFFFF, 1'b0, 1'b1, 1'b1},  // Equal operand
    '{OP_LDI, 16'h0F0F, 16'h0F0F, 16'hFFFF, 1'b0, 1'b0, 1'b1},
    '{OP_AND, 16'h00FF, 16'h000F, 16'hFFFF, 1'b0, 1'b0, 1'b1},
    '{OP_OR,  16'hF000, 16'hF00F, 16'hFFFF, 1'b1, 1'b0, 1'b1},
    '{OP_XOR, 16'hFFFF, 16'h0FF0, 16'hFFFF, 1'b0, 1'b0, 1'b1},
    '{OP_NOT, 16'h0000, 16'hF00F, 16'hFFFF, 1'b1, 1'b0, 1'b1},
    '{OP_LDI, 16'h1234, 16'h1234, 16'hFFFF, 1'b0, 1'b0, 1'b1},
    '{OP_MUL, 16'h0100, 16'h3400, 16'h0012, 1'b0, 1'b0, 1'b1},  // High word nonzero
    '{OP_LDI, 16'h0003, 16'h0003, 16'h0012, 1'b0, 1'b0, 1'b1},
    '{OP_MUL, 16'h0005, 16'h000F, 16'h0000, 1'b0, 1'b0, 1'b0},  // Small product
    '{OP_MUL, 16'h0000, 16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0},
    '{OP_LDI, 16'hFFFF, 16'hFFFF, 16'h0000, 1'b1, 1'b0, 1'b0},
    '{OP_MUL, 16'hFFFF, 16'h0001, 16'hFFFE, 1'b0, 1'b0, 1'b1},  // Largest product
    '{OP_ADD, 16'hFFFF, 16'h0000, 16'hFFFE, 1'b0, 1'b1, 1'b1}
};

`endif

//--- testbench/tb_neander_exec.sv
/*
 * Testbench for the execution unit top level
 *   - clock, reset and watchdog
 *   - four-phase command driver and response handler
 *   - compare task and table loop
 */
`timescale 1ns/1ps

module tb_neander_exec;
    import neander_pkg::*;

    `include "tb_vectors.svh"

    // --------------------------------------------------
    // Timing
    // --------------------------------------------------
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int DRIVE_DELAY    = 1;       // ns after the rising edge
    localparam int MAX_WAIT       = 5;       // Longest random ack delay in cycles
    localparam int TIMEOUT_CYCLES = NUM_VECS * (DATA_W + 30) + RESET_CYCLES;
    localparam int SEED           = 87845;

    logic    clk;
    logic    reset;
    logic    cmd_req;
    cmd_t    cmd;
    logic    rsp_ack;
    logic    cmd_ack;
    logic    rsp_req;
    result_t rsp;
    int      rsp_count;                      // Rises of rsp_req seen so far

    neander_exec_top dut (
        .clk     (clk),
        .reset   (reset),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .rsp_ack (rsp_ack),
        .cmd_ack (cmd_ack),
        .rsp_req (rsp_req),
        .rsp     (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            abort_run("DUT output differs from the expected value");
        end
    endtask

    // Rising edge, then the drive and sample offset
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // --------------------------------------------------
    // Handshake processes
    // --------------------------------------------------
    task automatic send_commands();
        for (int i = 0; i < NUM_VECS; i++) begin
            cmd.opcode  = VECTORS[i].opcode;
            cmd.operand = VECTORS[i].operand;
            cmd_req     = 1'b1;              // Phase 1
            do begin
                next_cycle();
            end while (!cmd_ack);
            cmd_req = 1'b0;                  // Phase 3
            do begin
                next_cycle();
            end while (cmd_ack);
        end
    endtask

    task automatic collect_responses();
        for (int i = 0; i < NUM_VECS; i++) begin
            do begin
                next_cycle();
            end while (!rsp_req);
            // rsp is stable while rsp_req is high
            check_value($sformatf("row %0d rsp.ac", i), VECTORS[i].ac, rsp.ac);
            check_value($sformatf("row %0d rsp.x", i), VECTORS[i].x, rsp.x);
            check_value($sformatf("row %0d rsp.flags.n", i), DATA_W'(VECTORS[i].n),
                        DATA_W'(rsp.flags.n));
            check_value($sformatf("row %0d rsp.flags.z", i), DATA_W'(VECTORS[i].z),
                        DATA_W'(rsp.flags.z));
            check_value($sformatf("row %0d rsp.flags.c", i), DATA_W'(VECTORS[i].c),
                        DATA_W'(rsp.flags.c));
            repeat ($urandom_range(MAX_WAIT, 0)) next_cycle();
            rsp_ack = 1'b1;
            do begin
                next_cycle();
            end while (rsp_req);
            repeat ($urandom_range(MAX_WAIT, 0)) next_cycle();  // Back-pressure on the core
            rsp_ack = 1'b0;
        end
    endtask

    // Counts each rise of rsp_req for the final tally
    initial begin
        logic req_prev;
        req_prev  = 1'b0;
        rsp_count = 0;
        forever begin
            next_cycle();
            if (rsp_req && !req_prev)
                rsp_count++;
            req_prev = rsp_req;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));
        clk     = 1'b0;
        reset   = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        rsp_ack = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_value("cmd_ack", '0, DATA_W'(cmd_ack));      // Both ports idle after reset
        check_value("rsp_req", '0, DATA_W'(rsp_req));
        fork
            send_commands();
            collect_responses();
        join
        repeat (DATA_W + 2 * MAX_WAIT) next_cycle();       // Quiet period for a stray result
        if (rsp_count == NUM_VECS) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d responses arrived for %0d commands",
                                rsp_count, NUM_VECS));
        end
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("run timed out waiting for a handshake");
    end

endmodule

//--- neander_exec.f
+incdir+include
verilog/neander_pkg.sv
verilog/cmd_receiver.sv
verilog/seq_multiplier.sv
verilog/exec_core.sv
verilog/result_sender.sv
verilog/neander_exec_top.sv
testbench/tb_neander_exec.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execution unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_neander_exec \
    --Mdir obj_dir \
    -f neander_exec.f

# The simulator exit status is checked through the log below
obj_dir/Vtb_neander_exec 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failures"
